// File: Makefile
TOP := segre_mem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f segre_mem.f --top-module $(TOP)

sim:
	verilator --binary --timing -f segre_mem.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// File: dv/dcache_stimulus.txt
# op (L load, S store)  size (B, H, W)  address (hex)  store data (hex)  expected load (hex)
# Store lines carry 00000000 as expected value, load lines carry 00000000 as store data
L W 00000200 00000000 00000000
L B 00000abc 00000000 00000000
S W 00000100 deadbeef 00000000
L W 00000100 00000000 deadbeef
L W 00000104 00000000 00000000
L W 00000100 00000000 deadbeef
S B 00000101 000000a5 00000000
S H 00000102 00001234 00000000
L W 00000100 00000000 1234a5ef
L B 00000103 00000000 00000012
L H 00000100 00000000 0000a5ef
S B 00000108 ffffff77 00000000
L W 00000108 00000000 00000077
S W 00000310 11112222 00000000
S W 00000350 33334444 00000000
L W 00000310 00000000 11112222
L W 00000350 00000000 33334444
L W 00000310 00000000 11112222
S H 00000352 0000abcd 00000000
L W 00000350 00000000 abcd4444
S W 00000400 a0a1a2a3 00000000
S W 00000414 b0b1b2b3 00000000
S W 00000428 c0c1c2c3 00000000
S W 0000043c d0d1d2d3 00000000
S W 00000450 e0e1e2e3 00000000
S W 00000464 f0f1f2f3 00000000
L W 00000400 00000000 a0a1a2a3
L W 00000414 00000000 b0b1b2b3
L W 00000428 00000000 c0c1c2c3
L W 0000043c 00000000 d0d1d2d3
L W 00000450 00000000 e0e1e2e3
L W 00000464 00000000 f0f1f2f3
L W 00000464 00000000 f0f1f2f3
L B 0000042b 00000000 000000c0

// File: dv/segre_mem_tb.sv
module segre_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import segre_pkg::*;

    localparam string STIM_FILE = "dv/dcache_stimulus.txt";
    localparam int READY_TIMEOUT = 200;
    localparam int HIT_CYCLES = 2;

    logic clk;
    logic reset;
    logic rd;
    logic wr;
    memop_data_type_e data_type;
    logic [WORD_SIZE-1:0] addr;
    logic [WORD_SIZE-1:0] data;
    logic ready;
    logic [WORD_SIZE-1:0] rd_data;

    // Parsed stimulus, one entry per access
    bit is_store_q [$];
    memop_data_type_e size_q [$];
    logic [WORD_SIZE-1:0] addr_q [$];
    logic [WORD_SIZE-1:0] data_q [$];
    logic [WORD_SIZE-1:0] expect_q [$];

    // Reference byte memory and a tag model to predict load hits
    logic [7:0] ref_mem [MEM_BYTES];
    bit line_valid [DCACHE_LINES];
    logic [TAG_BITS-1:0] line_tag [DCACHE_LINES];

    int pass_count;
    int fail_count;
    int bad_lines;
    bit aborted;

    segre_mem dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .rd_i        (rd),
        .wr_i        (wr),
        .data_type_i (data_type),
        .addr_i      (addr),
        .data_i      (data),
        .ready_o     (ready),
        .rd_data_o   (rd_data)
    );

    always #50 clk = ~clk;

    function automatic int size_bytes(memop_data_type_e size);
        case (size)
            BYTE: return 1;
            HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // Little-endian, zero-extended
    function automatic logic [WORD_SIZE-1:0] ref_read(logic [WORD_SIZE-1:0] a,
                                                      memop_data_type_e size);
        logic [WORD_SIZE-1:0] v;
        v = '0;
        for (int i = 0; i < size_bytes(size); i++) begin
            v[8*i +: 8] = ref_mem[MEM_ADDR_BITS'(a + i)];
        end
        return v;
    endfunction

    task automatic ref_write(logic [WORD_SIZE-1:0] a, memop_data_type_e size,
                             logic [WORD_SIZE-1:0] d);
        for (int i = 0; i < size_bytes(size); i++) begin
            ref_mem[MEM_ADDR_BITS'(a + i)] = d[8*i +: 8];
        end
    endtask

    task automatic read_stimulus();
        int fd;
        int line_no;
        int fields;
        string line;
        logic [7:0] op_c;
        logic [7:0] size_c;
        logic [WORD_SIZE-1:0] a;
        logic [WORD_SIZE-1:0] d;
        logic [WORD_SIZE-1:0] e;
        memop_data_type_e size;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            aborted = 1'b1;
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %s %h %h %h", op_c, size_c, a, d, e);
            size = (size_c == "B") ? BYTE : (size_c == "H") ? HALF : WORD;
            if (fields != 5 || !(op_c inside {"L", "S"}) || !(size_c inside {"B", "H", "W"})
                    || (a % size_bytes(size)) != 0 || (a + size_bytes(size)) > MEM_BYTES) begin
                $display("Stimulus line %0d is malformed or has a bad address", line_no);
                bad_lines++;
                continue;
            end
            // Replay on the reference memory to confirm the file's expected value
            if (op_c == "S") begin
                ref_write(a, size, d);
            end else if (ref_read(a, size) !== e) begin
                $display("[ERROR] %0t: stimulus line %0d expects %08h, reference gives %08h",
                         $time, line_no, e, ref_read(a, size));
                bad_lines++;
            end
            is_store_q.push_back(op_c == "S");
            size_q.push_back(size);
            addr_q.push_back(a);
            data_q.push_back(d);
            expect_q.push_back(e);
        end
        $fclose(fd);
    endtask

    task automatic check_idle();
        bit ok;
        ok = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (ready !== 1'b0) begin
                $display("[ERROR] %0t: ready_o is high with no request pending", $time);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("Test 0: ready_o idle after reset %s", ok ? "ok" : "wrong");
    endtask

    task automatic run_test(input int i);
        logic [INDEX_BITS-1:0] index;
        logic [TAG_BITS-1:0] tag;
        logic [WORD_SIZE-1:0] value;
        bit hit;
        bit ok;
        int cycles;
        index = addr_q[i][LINE_OFFSET_BITS +: INDEX_BITS];
        tag = addr_q[i][WORD_SIZE-1 -: TAG_BITS];
        hit = !is_store_q[i] && line_valid[index] && (line_tag[index] == tag);
        // Load misses allocate, stores never do
        if (!is_store_q[i]) begin
            line_valid[index] = 1'b1;
            line_tag[index] = tag;
        end

        @(negedge clk);
        rd = !is_store_q[i];
        wr = is_store_q[i];
        data_type = size_q[i];
        addr = addr_q[i];
        data = data_q[i];
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ready && cycles < READY_TIMEOUT);
        value = rd_data;
        rd = 1'b0;
        wr = 1'b0;

        if (!ready) begin
            $display("Test %0d: the DUT gave no ready_o within %0d cycles, run stopped",
                     i + 1, READY_TIMEOUT);
            fail_count++;
            aborted = 1'b1;
            return;
        end
        ok = 1'b1;
        if (!is_store_q[i] && value !== expect_q[i]) begin
            $display("[ERROR] %0t: load %s at %08h returned %08h, expected %08h",
                     $time, size_q[i].name(), addr_q[i], value, expect_q[i]);
            ok = 1'b0;
        end
        if (hit && cycles != HIT_CYCLES) begin
            $display("[ERROR] %0t: load hit at %08h took %0d cycles, expected %0d",
                     $time, addr_q[i], cycles, HIT_CYCLES);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("Test %0d: %s %s at %08h%s in %0d cycles %s", i + 1,
                 is_store_q[i] ? "store" : "load", size_q[i].name(), addr_q[i],
                 hit ? " (hit)" : "", cycles, ok ? "ok" : "wrong");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        rd = 1'b0;
        wr = 1'b0;
        data_type = WORD;
        addr = '0;
        data = '0;
        pass_count = 0;
        fail_count = 0;
        bad_lines = 0;
        aborted = 1'b0;
        $timeformat(-9, 1, " ns", 0);
        foreach (ref_mem[i]) begin
            ref_mem[i] = 8'h00;
        end
        foreach (line_valid[i]) begin
            line_valid[i] = 1'b0;
        end

        read_stimulus();
        if (is_store_q.size() == 0 && !aborted) begin
            $display("The stimulus file holds no accesses");
            aborted = 1'b1;
        end

        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_idle();
        for (int i = 0; i < is_store_q.size() && !aborted; i++) begin
            run_test(i);
        end

        $display("Tests: %0d passed, %0d failed, %0d bad stimulus lines",
                 pass_count, fail_count, bad_lines);
        if (!aborted && fail_count == 0 && bad_lines == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : segre_mem_tb

// File: segre_mem.f
src/segre_pkg.sv
src/memory.sv
src/mem_req_queue.sv
src/dcache.sv
src/segre_mem.sv
dv/segre_mem_tb.sv

// File: src/dcache.sv
module dcache (
    input  logic clk_i,
    input  logic reset_i,

    // Core side, held until ready_o
    input  logic rd_i,
    input  logic wr_i,
    input  segre_pkg::memop_data_type_e data_type_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] data_i,
    output logic ready_o,
    output logic [segre_pkg::WORD_SIZE-1:0] rd_data_o,

    // Request queue
    input  logic q_full_i,
    output logic q_push_o,
    output logic q_is_read_o,
    output segre_pkg::memop_data_type_e q_type_o,
    output logic [segre_pkg::WORD_SIZE-1:0] q_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0] q_data_o,

    // Line fill returned by memory
    input  logic fill_valid_i,
    input  logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] fill_line_i
);
    import segre_pkg::*;

    dcache_state_e state_q;
    dcache_state_e state_d;

    logic [DCACHE_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0] tag_q [DCACHE_LINES];
    logic [CACHE_LINE_SIZE_BYTES-1:0][7:0] line_q [DCACHE_LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag;
    logic [LINE_OFFSET_BITS-1:0] offset;
    logic [CACHE_LINE_SIZE_BYTES-1:0][7:0] sel_line;
    logic hit;
    logic store_merge;
    logic refill_done;

    // Address split
    assign index  = addr_i[LINE_OFFSET_BITS +: INDEX_BITS];
    assign tag    = addr_i[WORD_SIZE-1 -: TAG_BITS];
    assign offset = addr_i[LINE_OFFSET_BITS-1:0];

    assign sel_line    = line_q[index];
    assign hit         = valid_q[index] && (tag_q[index] == tag);
    assign refill_done = (state_q == REFILL) && fill_valid_i;

    always_comb begin
        state_d     = state_q;
        q_push_o    = 1'b0;
        store_merge = 1'b0;
        case (state_q)
            IDLE: begin
                if (rd_i || wr_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (wr_i) begin
                    // Write-through, no allocate on a miss
                    if (!q_full_i) begin
                        q_push_o    = 1'b1;
                        store_merge = hit;
                        state_d     = RESPOND;
                    end
                end else if (hit) begin
                    state_d = RESPOND;
                end else if (!q_full_i) begin
                    q_push_o = 1'b1;
                    state_d  = REFILL;
                end
            end
            REFILL: begin
                if (fill_valid_i) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign ready_o     = (state_q == RESPOND);
    assign q_is_read_o = rd_i;
    assign q_type_o    = data_type_i;
    assign q_data_o    = data_i;
    // Fills fetch the whole line
    assign q_addr_o    = rd_i ? {addr_i[WORD_SIZE-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}}
                              : addr_i;

    // Load data, zero-extended
    always_comb begin
        case (data_type_i)
            BYTE: rd_data_o = {{(WORD_SIZE-8){1'b0}}, sel_line[offset]};
            HALF: rd_data_o = {{(WORD_SIZE-16){1'b0}}, sel_line[offset + 1'b1], sel_line[offset]};
            WORD: rd_data_o = {sel_line[offset + 2'd3], sel_line[offset + 2'd2],
                               sel_line[offset + 1'b1], sel_line[offset]};
            default: rd_data_o = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (refill_done) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    // Line and tag arrays
    always_ff @(posedge clk_i) begin
        if (refill_done) begin
            line_q[index] <= fill_line_i;
            tag_q[index]  <= tag;
        end else if (store_merge) begin
            case (data_type_i)
                BYTE: begin
                    line_q[index][offset] <= data_i[7:0];
                end
                HALF: begin
                    line_q[index][offset]        <= data_i[7:0];
                    line_q[index][offset + 1'b1] <= data_i[15:8];
                end
                WORD: begin
                    line_q[index][offset]         <= data_i[7:0];
                    line_q[index][offset + 1'b1]  <= data_i[15:8];
                    line_q[index][offset + 2'd2]  <= data_i[23:16];
                    line_q[index][offset + 2'd3]  <= data_i[31:24];
                end
                default: ;
            endcase
        end
    end

endmodule : dcache

// File: src/mem_req_queue.sv
module mem_req_queue (
    input  logic clk_i,
    input  logic reset_i,

    // From the cache
    input  logic push_i,
    input  logic is_read_i,
    input  segre_pkg::memop_data_type_e type_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] data_i,
    output logic full_o,
    output logic fill_valid_o,

    // To main memory
    output logic mem_rd_o,
    output logic mem_wr_o,
    output segre_pkg::memop_data_type_e mem_type_o,
    output logic [segre_pkg::WORD_SIZE-1:0] mem_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0] mem_data_o,
    input  logic mem_ready_i
);
    import segre_pkg::*;

    // Entry storage
    logic is_read_q [REQ_QUEUE_DEPTH];
    memop_data_type_e type_q [REQ_QUEUE_DEPTH];
    logic [WORD_SIZE-1:0] addr_q [REQ_QUEUE_DEPTH];
    logic [WORD_SIZE-1:0] data_q [REQ_QUEUE_DEPTH];

    logic [QUEUE_PTR_BITS-1:0] wr_ptr_q;
    logic [QUEUE_PTR_BITS-1:0] rd_ptr_q;
    logic [QUEUE_CNT_BITS-1:0] count_q;
    logic outstanding_q;

    logic push;
    logic pop;
    logic issue;

    assign full_o = (count_q == QUEUE_CNT_BITS'(REQ_QUEUE_DEPTH));
    assign push   = push_i && !full_o;
    assign pop    = mem_ready_i && outstanding_q;

    // Only one request in flight, head stays until memory answers
    assign issue = !outstanding_q && (count_q != '0);

    assign mem_rd_o   = issue && is_read_q[rd_ptr_q];
    assign mem_wr_o   = issue && !is_read_q[rd_ptr_q];
    assign mem_type_o = type_q[rd_ptr_q];
    assign mem_addr_o = addr_q[rd_ptr_q];
    assign mem_data_o = data_q[rd_ptr_q];

    // Line itself travels directly from memory to the cache
    assign fill_valid_o = pop && is_read_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            is_read_q[wr_ptr_q] <= is_read_i;
            type_q[wr_ptr_q]    <= type_i;
            addr_q[wr_ptr_q]    <= addr_i;
            data_q[wr_ptr_q]    <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            outstanding_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end

            if (issue) begin
                outstanding_q <= 1'b1;
            end else if (pop) begin
                outstanding_q <= 1'b0;
            end
        end
    end

endmodule : mem_req_queue

// File: src/memory.sv
module memory (
    input  logic clk_i,
    input  logic reset_i,

    // Request strobes, one cycle each
    input  logic rd_i,
    input  logic wr_i,
    input  segre_pkg::memop_data_type_e data_type_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] data_i,

    output logic mem_ready_o,
    output logic [segre_pkg::CACHE_LINE_SIZE_BYTES-1:0][7:0] cache_line_o
);
    import segre_pkg::*;

    logic [7:0] mem_q [MEM_BYTES];

    logic busy_q;
    logic [LATENCY_CNT_BITS-1:0] cnt_q;
    logic finish;

    // Request captured at the strobe
    logic req_rd_q;
    memop_data_type_e req_type_q;
    logic [MEM_ADDR_BITS-1:0] req_addr_q;
    logic [WORD_SIZE-1:0] req_data_q;
    logic [MEM_ADDR_BITS-1:0] line_base;

    // Memory contents start at zero and survive reset
    initial begin
        foreach (mem_q[i]) begin
            mem_q[i] = 8'h00;
        end
    end

    assign finish = busy_q && (cnt_q == LATENCY_CNT_BITS'(MEM_LATENCY - 1));
    assign line_base = {req_addr_q[MEM_ADDR_BITS-1:LINE_OFFSET_BITS],
                        {LINE_OFFSET_BITS{1'b0}}};

    // Latency counter, strobes while busy are dropped
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            cnt_q       <= '0;
            mem_ready_o <= 1'b0;
        end else begin
            mem_ready_o <= 1'b0;
            if (!busy_q) begin
                if (rd_i || wr_i) begin
                    busy_q <= 1'b1;
                    cnt_q  <= LATENCY_CNT_BITS'(1);
                end
            end else if (finish) begin
                busy_q      <= 1'b0;
                cnt_q       <= '0;
                mem_ready_o <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busy_q && (rd_i || wr_i)) begin
            req_rd_q   <= rd_i;
            req_type_q <= data_type_i;
            req_addr_q <= addr_i[MEM_ADDR_BITS-1:0];
            req_data_q <= data_i;
        end
    end

    // Array access lands in the same edge that raises mem_ready_o
    always_ff @(posedge clk_i) begin
        if (finish) begin
            if (req_rd_q) begin
                for (int i = 0; i < CACHE_LINE_SIZE_BYTES; i++) begin
                    cache_line_o[i] <= mem_q[line_base + MEM_ADDR_BITS'(i)];
                end
            end else begin
                // Little-endian byte order
                case (req_type_q)
                    BYTE: begin
                        mem_q[req_addr_q] <= req_data_q[7:0];
                    end
                    HALF: begin
                        mem_q[req_addr_q]        <= req_data_q[7:0];
                        mem_q[req_addr_q + 1'b1] <= req_data_q[15:8];
                    end
                    WORD: begin
                        mem_q[req_addr_q]                    <= req_data_q[7:0];
                        mem_q[req_addr_q + 1'b1]             <= req_data_q[15:8];
                        mem_q[req_addr_q + MEM_ADDR_BITS'(2)] <= req_data_q[23:16];
                        mem_q[req_addr_q + MEM_ADDR_BITS'(3)] <= req_data_q[31:24];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule : memory

// File: src/segre_mem.sv
module segre_mem (
    input  logic clk_i,
    input  logic reset_i,
    input  logic rd_i,
    input  logic wr_i,
    input  segre_pkg::memop_data_type_e data_type_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] data_i,
    output logic ready_o,
    output logic [segre_pkg::WORD_SIZE-1:0] rd_data_o
);
    import segre_pkg::*;

    // Cache to queue
    logic q_push;
    logic q_is_read;
    memop_data_type_e q_type;
    logic [WORD_SIZE-1:0] q_addr;
    logic [WORD_SIZE-1:0] q_data;
    logic q_full;
    logic fill_valid;

    // Queue to memory
    logic mem_rd;
    logic mem_wr;
    memop_data_type_e mem_type;
    logic [WORD_SIZE-1:0] mem_addr;
    logic [WORD_SIZE-1:0] mem_data;
    logic mem_ready;
    logic [CACHE_LINE_SIZE_BYTES-1:0][7:0] cache_line;

    dcache u_dcache (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .rd_i         (rd_i),
        .wr_i         (wr_i),
        .data_type_i  (data_type_i),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .ready_o      (ready_o),
        .rd_data_o    (rd_data_o),
        .q_full_i     (q_full),
        .q_push_o     (q_push),
        .q_is_read_o  (q_is_read),
        .q_type_o     (q_type),
        .q_addr_o     (q_addr),
        .q_data_o     (q_data),
        .fill_valid_i (fill_valid),
        .fill_line_i  (cache_line)
    );

    mem_req_queue u_mem_req_queue (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .push_i       (q_push),
        .is_read_i    (q_is_read),
        .type_i       (q_type),
        .addr_i       (q_addr),
        .data_i       (q_data),
        .full_o       (q_full),
        .fill_valid_o (fill_valid),
        .mem_rd_o     (mem_rd),
        .mem_wr_o     (mem_wr),
        .mem_type_o   (mem_type),
        .mem_addr_o   (mem_addr),
        .mem_data_o   (mem_data),
        .mem_ready_i  (mem_ready)
    );

    memory u_memory (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .rd_i         (mem_rd),
        .wr_i         (mem_wr),
        .data_type_i  (mem_type),
        .addr_i       (mem_addr),
        .data_i       (mem_data),
        .mem_ready_o  (mem_ready),
        .cache_line_o (cache_line)
    );

endmodule : segre_mem

// File: src/segre_pkg.sv
package segre_pkg;

    // Data path and address width
    localparam int WORD_SIZE = 32;

    // Cache line geometry
    localparam int CACHE_LINE_SIZE_BYTES = 16;
    localparam int LINE_OFFSET_BITS = 4;

    // Main memory
    localparam int MEM_BYTES = 4096;
    localparam int MEM_ADDR_BITS = $clog2(MEM_BYTES);
    localparam int MEM_LATENCY = 9;
    localparam int LATENCY_CNT_BITS = $clog2(MEM_LATENCY + 1);

    // Direct-mapped data cache, index sits right above the line offset
    localparam int DCACHE_LINES = 4;
    localparam int INDEX_BITS = $clog2(DCACHE_LINES);
    localparam int TAG_BITS = WORD_SIZE - INDEX_BITS - LINE_OFFSET_BITS;

    // Memory request queue
    localparam int REQ_QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_BITS = $clog2(REQ_QUEUE_DEPTH);
    localparam int QUEUE_CNT_BITS = $clog2(REQ_QUEUE_DEPTH + 1);

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_data_type_e;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } dcache_state_e;

endpackage : segre_pkg
